// ==== logic/datapath_controller.sv ====
`timescale 1ns/1ps

module datapath_controller #(
    parameter int IN_DEPTH = 128,
    parameter int WT_DEPTH = 64,
    parameter int PS_DEPTH = 32
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  pe_cfg_pkg::pe_conf_t i_conf,
    input  logic                 i_in_rdy,
    output logic                 o_in_ack,
    input  logic                 i_wt_rdy,
    output logic                 o_wt_ack,
    output logic                 o_ps_rdy,
    input  logic                 i_ps_ack,
    output pe_ctl_pkg::pad_ctl_t o_in_pad_ctl,
    output pe_ctl_pkg::pad_ctl_t o_wt_pad_ctl,
    output pe_ctl_pkg::pad_ctl_t o_ps_rd_ctl,
    output pe_ctl_pkg::mac_ctl_t o_mac_ctl,
    output logic                 o_busy,
    output logic                 o_done
);
    import pe_cfg_pkg::*;
    import pe_ctl_pkg::*;

    localparam int IN_CW = $clog2(IN_DEPTH + 1);
    localparam int WT_CW = $clog2(WT_DEPTH + 1);
    localparam int PS_AW = $clog2(PS_DEPTH);

    // compute loop levels, innermost first
    localparam int LV_R = 0;
    localparam int LV_C = 1;
    localparam int LV_M = 2;
    localparam int LV_X = 3;

    typedef enum logic [2:0] {IDLE, LOAD, COMPUTE, FLUSH, DRAIN} state_t;

    state_t                     state;
    state_t                     state_nxt;
    pe_conf_t                   conf_q;
    logic                       start_go;
    pad_addr_t                  row_len;
    logic [IN_CW-1:0]           in_total;
    logic [IN_CW-1:0]           in_cnt;
    logic [WT_CW-1:0]           wt_total;
    logic [WT_CW-1:0]           wt_cnt;
    logic                       in_done;
    logic                       wt_done;
    logic                       in_xfer;
    logic                       wt_xfer;
    logic [3:0][IDX_W-1:0]      cp_size;
    logic [3:0][IDX_W-1:0]      cp_idx;
    logic [3:0]                 cp_end;
    logic                       cp_last;
    logic                       cp_inc;
    pad_addr_t                  in_raddr;
    pad_addr_t                  wt_raddr;
    logic [PS_AW-1:0]           ps_waddr;
    logic [1:0][IDX_W-1:0]      dr_size;
    logic [1:0][IDX_W-1:0]      dr_idx;
    logic                       dr_last;
    logic [PS_AW-1:0]           dr_addr;
    logic                       flush_q;
    logic                       rd_all_q;
    logic                       rd_go;
    logic                       drain_fin;

    // psum slot for output pixel x, filter m
    function automatic logic [PS_AW-1:0] ps_index(
        input logic [IDX_W-1:0] x,
        input logic [IDX_W-1:0] m,
        input logic [IDX_W-1:0] pm
    );
        return PS_AW'(x) * PS_AW'(pm) + PS_AW'(m);
    endfunction

    assign start_go = (state == IDLE) && i_start;
    assign o_busy   = (state != IDLE);

    // ====================
    // load phase
    // ====================
    assign row_len  = (PAD_AW'(conf_q.tw) - 1'b1) * PAD_AW'(conf_q.u) + PAD_AW'(conf_q.r);
    assign in_total = IN_CW'(PAD_AW'(conf_q.pch) * row_len);
    assign wt_total = WT_CW'(PAD_AW'(conf_q.pch) * PAD_AW'(conf_q.r) * PAD_AW'(conf_q.pm));

    assign in_done  = (in_cnt == in_total);
    assign wt_done  = (wt_cnt == wt_total);
    assign o_in_ack = (state == LOAD) && !in_done;
    assign o_wt_ack = (state == LOAD) && !wt_done;
    assign in_xfer  = o_in_ack && i_in_rdy;
    assign wt_xfer  = o_wt_ack && i_wt_rdy;

    // ====================
    // compute phase
    // ====================
    assign cp_inc  = (state == COMPUTE);
    assign cp_size = {IDX_W'(conf_q.tw), IDX_W'(conf_q.pm), IDX_W'(conf_q.pch), IDX_W'(conf_q.r)};

    loop_counter #(
        .NDEPTH (4),
        .IDXW   (IDX_W)
    ) compute_lp (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (start_go),
        .i_inc   (cp_inc),
        .i_size  (cp_size),
        .o_idx   (cp_idx),
        .o_end   (cp_end),
        .o_last  (cp_last)
    );

    // window of pixel x starts at x*U inside channel c
    assign in_raddr = PAD_AW'(cp_idx[LV_C]) * row_len
                    + PAD_AW'(cp_idx[LV_X]) * PAD_AW'(conf_q.u)
                    + PAD_AW'(cp_idx[LV_R]);
    // weights stored c, r, m with m fastest
    assign wt_raddr = (PAD_AW'(cp_idx[LV_C]) * PAD_AW'(conf_q.r) + PAD_AW'(cp_idx[LV_R]))
                    * PAD_AW'(conf_q.pm) + PAD_AW'(cp_idx[LV_M]);
    assign ps_waddr = ps_index(cp_idx[LV_X], cp_idx[LV_M], IDX_W'(conf_q.pm));

    assign o_in_pad_ctl = '{write: in_xfer, waddr: PAD_AW'(in_cnt), read: cp_inc, raddr: in_raddr};
    assign o_wt_pad_ctl = '{write: wt_xfer, waddr: PAD_AW'(wt_cnt), read: cp_inc, raddr: wt_raddr};

    assign o_mac_ctl = '{
        valid: cp_inc,
        first: (cp_idx[LV_C] == '0) && (cp_idx[LV_R] == '0),
        last:  cp_end[LV_C] && cp_end[LV_R],
        paddr: PS_ADDR_W'(ps_waddr)
    };

    // ====================
    // drain phase
    // ====================
    assign dr_size = {IDX_W'(conf_q.tw), IDX_W'(conf_q.pm)};

    loop_counter #(
        .NDEPTH (2),
        .IDXW   (IDX_W)
    ) drain_lp (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (start_go),
        .i_inc   (rd_go),
        .i_size  (dr_size),
        .o_idx   (dr_idx),
        .o_end   (),
        .o_last  (dr_last)
    );

    assign dr_addr = ps_index(dr_idx[1], dr_idx[0], IDX_W'(conf_q.pm));

    // next read once the presented word is taken
    assign rd_go     = (state == DRAIN) && !rd_all_q && (!o_ps_rdy || i_ps_ack);
    assign drain_fin = (state == DRAIN) && rd_all_q && o_ps_rdy && i_ps_ack;

    assign o_ps_rd_ctl = '{write: 1'b0, waddr: '0, read: rd_go, raddr: PAD_AW'(dr_addr)};

    // ====================
    // state machine
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (i_start) state_nxt = LOAD;
            LOAD:    if (in_done && wt_done) state_nxt = COMPUTE;
            COMPUTE: if (cp_last) state_nxt = FLUSH;
            // two cycles for the MAC pipeline to write its last psum
            FLUSH:   if (flush_q) state_nxt = DRAIN;
            DRAIN:   if (drain_fin) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state    <= IDLE;
            o_done   <= 1'b0;
            o_ps_rdy <= 1'b0;
            flush_q  <= 1'b0;
            rd_all_q <= 1'b0;
            in_cnt   <= '0;
            wt_cnt   <= '0;
        end else begin
            state   <= state_nxt;
            o_done  <= drain_fin;
            flush_q <= (state == FLUSH) && !flush_q;
            if (rd_go) begin
                o_ps_rdy <= 1'b1;
            end else if (i_ps_ack) begin
                o_ps_rdy <= 1'b0;
            end
            if (start_go) begin
                in_cnt   <= '0;
                wt_cnt   <= '0;
                rd_all_q <= 1'b0;
            end else begin
                if (in_xfer) in_cnt <= in_cnt + 1'b1;
                if (wt_xfer) wt_cnt <= wt_cnt + 1'b1;
                if (rd_go && dr_last) rd_all_q <= 1'b1;
            end
        end
    end

    // shape held for the whole run
    always_ff @(posedge i_clk) begin
        if (start_go) begin
            conf_q <= i_conf;
        end
    end

endmodule

// ==== logic/loop_counter.sv ====
`timescale 1ns/1ps

module loop_counter #(
    parameter int NDEPTH = 2,
    parameter int IDXW   = 4
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_clear,
    input  logic                        i_inc,
    input  logic [NDEPTH-1:0][IDXW-1:0] i_size,
    output logic [NDEPTH-1:0][IDXW-1:0] o_idx,
    output logic [NDEPTH-1:0]           o_end,
    output logic                        o_last
);

    // per-level advance enable
    logic [NDEPTH-1:0] step;

    // level sits on its last value
    always_comb begin
        for (int i = 0; i < NDEPTH; i++) begin
            o_end[i] = (o_idx[i] == i_size[i] - 1'b1);
        end
    end

    // carry ripples outward from level 0
    always_comb begin
        logic carry;
        carry = i_inc;
        for (int i = 0; i < NDEPTH; i++) begin
            step[i] = carry;
            carry   = carry && o_end[i];
        end
    end

    assign o_last = &o_end;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            o_idx <= '0;
        end else begin
            for (int i = 0; i < NDEPTH; i++) begin
                if (step[i]) begin
                    // wrap after size-1
                    o_idx[i] <= o_end[i] ? '0 : o_idx[i] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/mac_unit.sv ====
`timescale 1ns/1ps

module mac_unit (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  pe_ctl_pkg::mac_ctl_t i_mac_ctl,
    input  pe_cfg_pkg::in_pix_t  i_in_pix,
    input  pe_cfg_pkg::wt_t      i_wt,
    output pe_ctl_pkg::pad_ctl_t o_ps_wr_ctl,
    output pe_cfg_pkg::psum_t    o_ps_wdata
);
    import pe_cfg_pkg::*;
    import pe_ctl_pkg::*;

    mac_ctl_t                                      ctl_q;
    logic signed [$bits(in_pix_t)+$bits(wt_t)-1:0] prod;
    psum_t                                         acc_q;
    logic                                          wr_q;
    logic [PS_ADDR_W-1:0]                          wr_addr_q;

    // pad data shows up one cycle after the op
    assign prod = i_in_pix * i_wt;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ctl_q <= '0;
            wr_q  <= 1'b0;
        end else begin
            ctl_q <= i_mac_ctl;
            wr_q  <= ctl_q.valid && ctl_q.last;
        end
    end

    // accumulate over channels and taps
    always_ff @(posedge i_clk) begin
        if (ctl_q.valid) begin
            acc_q <= ctl_q.first ? psum_t'(prod) : acc_q + psum_t'(prod);
        end
        if (ctl_q.valid && ctl_q.last) begin
            wr_addr_q <= ctl_q.paddr;
        end
    end

    // write half only, read half belongs to the controller
    assign o_ps_wr_ctl = '{write: wr_q, waddr: PAD_AW'(wr_addr_q), read: 1'b0, raddr: '0};
    assign o_ps_wdata  = acc_q;

endmodule

// ==== logic/pe_cfg_pkg.sv ====
package pe_cfg_pkg;

    // ====================
    // size limits
    // ====================
    localparam int MAX_PCH = 4;
    localparam int MAX_R   = 4;
    localparam int MAX_PM  = 4;
    localparam int MAX_TW  = 8;

    // widest input row, stride 2 with the largest filter
    localparam int MAX_ROW = (MAX_TW - 1) * 2 + MAX_R;

    // words per stream at the largest shape
    localparam int MAX_IN_WORDS = MAX_PCH * MAX_ROW;
    localparam int MAX_WT_WORDS = MAX_PCH * MAX_R * MAX_PM;
    localparam int MAX_PS_WORDS = MAX_TW * MAX_PM;

    // loop index width, tw is the widest dimension
    localparam int IDX_W = $clog2(MAX_TW + 1);

    // ====================
    // data types
    // ====================
    typedef logic signed [7:0]  in_pix_t;
    typedef logic signed [7:0]  wt_t;

    // 16-bit products, headroom for up to 256 accumulations
    typedef logic signed [23:0] psum_t;

    // ====================
    // shape configuration
    // ====================
    // latched once per run on the start strobe
    typedef struct packed {
        // input channels, 1..4
        logic [2:0] pch;
        // filter taps, 1..4
        logic [2:0] r;
        // filters, 1..4
        logic [2:0] pm;
        // output pixels, 1..8
        logic [3:0] tw;
        // stride, 1 or 2
        logic [1:0] u;
    } pe_conf_t;

endpackage

// ==== logic/pe_ctl_pkg.sv ====
package pe_ctl_pkg;

    // ====================
    // scratchpad control
    // ====================
    // address field is wide enough for the deepest pad
    localparam int PAD_AW = 8;

    typedef logic [PAD_AW-1:0] pad_addr_t;

    // write half and read half share one struct
    typedef struct packed {
        logic      write;
        pad_addr_t waddr;
        logic      read;
        pad_addr_t raddr;
    } pad_ctl_t;

    // ====================
    // MAC control
    // ====================
    // psum address width, 32 psum entries
    localparam int PS_ADDR_W = 5;

    // one per issued MAC op
    typedef struct packed {
        logic                 valid;
        // load the accumulator instead of adding
        logic                 first;
        // final term, write the psum out
        logic                 last;
        logic [PS_ADDR_W-1:0] paddr;
    } mac_ctl_t;

endpackage

// ==== logic/pe_top.sv ====
`timescale 1ns/1ps

module pe_top #(
    parameter int IN_DEPTH = 128,
    parameter int WT_DEPTH = 64,
    parameter int PS_DEPTH = 32
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  pe_cfg_pkg::pe_conf_t i_conf,
    input  logic                 i_in_rdy,
    input  pe_cfg_pkg::in_pix_t  i_in_data,
    output logic                 o_in_ack,
    input  logic                 i_wt_rdy,
    input  pe_cfg_pkg::wt_t      i_wt_data,
    output logic                 o_wt_ack,
    output logic                 o_ps_rdy,
    output pe_cfg_pkg::psum_t    o_ps_data,
    input  logic                 i_ps_ack,
    output logic                 o_busy,
    output logic                 o_done
);
    import pe_cfg_pkg::*;
    import pe_ctl_pkg::*;

    pad_ctl_t in_pad_ctl;
    pad_ctl_t wt_pad_ctl;
    pad_ctl_t ps_rd_ctl;
    pad_ctl_t ps_wr_ctl;
    pad_ctl_t ps_pad_ctl;
    mac_ctl_t mac_ctl;
    in_pix_t  in_pix;
    wt_t      wt;
    psum_t    ps_wdata;

    // ====================
    // control
    // ====================
    datapath_controller #(
        .IN_DEPTH (IN_DEPTH),
        .WT_DEPTH (WT_DEPTH),
        .PS_DEPTH (PS_DEPTH)
    ) dp_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_conf       (i_conf),
        .i_in_rdy     (i_in_rdy),
        .o_in_ack     (o_in_ack),
        .i_wt_rdy     (i_wt_rdy),
        .o_wt_ack     (o_wt_ack),
        .o_ps_rdy     (o_ps_rdy),
        .i_ps_ack     (i_ps_ack),
        .o_in_pad_ctl (in_pad_ctl),
        .o_wt_pad_ctl (wt_pad_ctl),
        .o_ps_rd_ctl  (ps_rd_ctl),
        .o_mac_ctl    (mac_ctl),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    // ====================
    // scratchpads
    // ====================
    scratch_pad #(
        .T_DATA (in_pix_t),
        .DEPTH  (IN_DEPTH)
    ) in_pad (
        .i_clk    (i_clk),
        .i_wr_ctl (in_pad_ctl),
        .i_rd_ctl (in_pad_ctl),
        .i_wdata  (i_in_data),
        .o_rdata  (in_pix)
    );

    scratch_pad #(
        .T_DATA (wt_t),
        .DEPTH  (WT_DEPTH)
    ) wt_pad (
        .i_clk    (i_clk),
        .i_wr_ctl (wt_pad_ctl),
        .i_rd_ctl (wt_pad_ctl),
        .i_wdata  (i_wt_data),
        .o_rdata  (wt)
    );

    // MAC writes, controller reads during drain
    assign ps_pad_ctl = '{
        write: ps_wr_ctl.write,
        waddr: ps_wr_ctl.waddr,
        read:  ps_rd_ctl.read,
        raddr: ps_rd_ctl.raddr
    };

    scratch_pad #(
        .T_DATA (psum_t),
        .DEPTH  (PS_DEPTH)
    ) ps_pad (
        .i_clk    (i_clk),
        .i_wr_ctl (ps_pad_ctl),
        .i_rd_ctl (ps_pad_ctl),
        .i_wdata  (ps_wdata),
        .o_rdata  (o_ps_data)
    );

    // ====================
    // MAC
    // ====================
    mac_unit mac (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_mac_ctl   (mac_ctl),
        .i_in_pix    (in_pix),
        .i_wt        (wt),
        .o_ps_wr_ctl (ps_wr_ctl),
        .o_ps_wdata  (ps_wdata)
    );

endmodule

// ==== logic/scratch_pad.sv ====
`timescale 1ns/1ps

module scratch_pad #(
    parameter type T_DATA = logic [7:0],
    parameter int  DEPTH  = 64
) (
    input  logic                 i_clk,
    input  pe_ctl_pkg::pad_ctl_t i_wr_ctl,
    input  pe_ctl_pkg::pad_ctl_t i_rd_ctl,
    input  T_DATA                i_wdata,
    output T_DATA                o_rdata
);

    localparam int AW = $clog2(DEPTH);

    T_DATA mem [DEPTH];

    // write port
    always_ff @(posedge i_clk) begin
        if (i_wr_ctl.write) begin
            mem[i_wr_ctl.waddr[AW-1:0]] <= i_wdata;
        end
    end

    // registered read, word holds until the next read strobe
    always_ff @(posedge i_clk) begin
        if (i_rd_ctl.read) begin
            o_rdata <= mem[i_rd_ctl.raddr[AW-1:0]];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the PE testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pe_tb \
    -Mdir obj_dir -f sim.f > sim.log 2>&1 &&
    ./obj_dir/Vpe_tb >> sim.log 2>&1

grep -q "^test passed$" sim.log && echo "PASS" || {
    echo "FAIL, see sim.log"
    exit 1
}

// ==== sim.f ====
logic/pe_cfg_pkg.sv
logic/pe_ctl_pkg.sv
logic/loop_counter.sv
logic/scratch_pad.sv
logic/datapath_controller.sv
logic/mac_unit.sv
logic/pe_top.sv
verif/pe_tb.sv

// ==== verif/pe_tb.sv ====
`timescale 1ns/1ps

module pe_tb;
    import pe_cfg_pkg::*;

    localparam int NUM_RUNS = 33;

    logic     clk       = 1'b0;
    logic     rst_n     = 1'b0;
    logic     i_start   = 1'b0;
    pe_conf_t i_conf    = '0;
    logic     i_in_rdy  = 1'b0;
    in_pix_t  i_in_data = '0;
    logic     i_wt_rdy  = 1'b0;
    wt_t      i_wt_data = '0;
    logic     i_ps_ack  = 1'b0;
    logic     o_in_ack;
    logic     o_wt_ack;
    logic     o_ps_rdy;
    psum_t    o_ps_data;
    logic     o_busy;
    logic     o_done;

    int       seed = 32'h405d_b7e3;
    pe_conf_t run_conf [NUM_RUNS];
    bit       run_gaps [NUM_RUNS];
    bit       run_poke [NUM_RUNS];
    pe_conf_t cur_conf;
    bit       run_gap_now = 1'b0;
    bit       feeding = 1'b0;
    bit       checking = 1'b0;
    int       in_total;
    int       wt_total;
    int       ps_total;
    int       in_idx;
    int       wt_idx;
    int       ps_cnt;
    int       done_cnt;
    bit       hold_wait;
    psum_t    hold_data;
    in_pix_t  in_mem [MAX_IN_WORDS];
    wt_t      wt_mem [MAX_WT_WORDS];

    always #50 clk = ~clk;

    pe_top #(
        .IN_DEPTH (128),
        .WT_DEPTH (64),
        .PS_DEPTH (32)
    ) pe_top_inst (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_start   (i_start),
        .i_conf    (i_conf),
        .i_in_rdy  (i_in_rdy),
        .i_in_data (i_in_data),
        .o_in_ack  (o_in_ack),
        .i_wt_rdy  (i_wt_rdy),
        .i_wt_data (i_wt_data),
        .o_wt_ack  (o_wt_ack),
        .o_ps_rdy  (o_ps_rdy),
        .o_ps_data (o_ps_data),
        .i_ps_ack  (i_ps_ack),
        .o_busy    (o_busy),
        .o_done    (o_done)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic int pick_in_range(input int lo, input int hi);
        int v;
        v = $random(seed) & 32'h7fff_ffff;
        return lo + v % (hi - lo + 1);
    endfunction

    function automatic pe_conf_t make_conf(input int pch, input int r, input int pm,
                                           input int tw, input int u);
        pe_conf_t c;
        c.pch = 3'(pch);
        c.r   = 3'(r);
        c.pm  = 3'(pm);
        c.tw  = 4'(tw);
        c.u   = 2'(u);
        return c;
    endfunction

    function automatic int row_words(input pe_conf_t c);
        return (int'(c.tw) - 1) * int'(c.u) + int'(c.r);
    endfunction

    // generous cycle bound for one run
    function automatic int run_cycles(input pe_conf_t c, input bit slow);
        int load;
        int total;
        load  = int'(c.pch) * row_words(c) + int'(c.pch) * int'(c.r) * int'(c.pm);
        total = load + int'(c.tw) * int'(c.pm) * (int'(c.pch) * int'(c.r) + 2) + 16;
        return slow ? 2 * total : total;
    endfunction

    // expected psum for filter m at output pixel x
    function automatic psum_t conv_ref(input pe_conf_t c, input int x, input int m);
        int    row;
        psum_t acc;
        row = row_words(c);
        acc = '0;
        for (int ch = 0; ch < int'(c.pch); ch++) begin
            for (int rr = 0; rr < int'(c.r); rr++) begin
                acc += psum_t'(in_mem[ch * row + x * int'(c.u) + rr])
                     * psum_t'(wt_mem[(ch * int'(c.r) + rr) * int'(c.pm) + m]);
            end
        end
        return acc;
    endfunction

    // ====================
    // stream sources
    // ====================
    // after the total, a word stays on offer that must never be taken
    always @(posedge clk) begin : feed_in
        bit taken;
        taken = i_in_rdy && o_in_ack;
        if (!feeding) begin
            in_idx = 0;
            i_in_rdy <= 1'b0;
        end else begin
            if (taken) begin
                assert (in_idx < in_total) else
                    abort_run("input word taken after the load total was reached");
                in_idx = in_idx + 1;
            end
            if (in_idx >= in_total) begin
                i_in_rdy  <= 1'b1;
                i_in_data <= '0;
            end else if (taken || !i_in_rdy) begin
                i_in_rdy  <= !run_gap_now || (pick_in_range(0, 3) != 0);
                i_in_data <= in_mem[in_idx];
            end
        end
    end

    always @(posedge clk) begin : feed_wt
        bit taken;
        taken = i_wt_rdy && o_wt_ack;
        if (!feeding) begin
            wt_idx = 0;
            i_wt_rdy <= 1'b0;
        end else begin
            if (taken) begin
                assert (wt_idx < wt_total) else
                    abort_run("weight word taken after the load total was reached");
                wt_idx = wt_idx + 1;
            end
            if (wt_idx >= wt_total) begin
                i_wt_rdy  <= 1'b1;
                i_wt_data <= '0;
            end else if (taken || !i_wt_rdy) begin
                i_wt_rdy  <= !run_gap_now || (pick_in_range(0, 3) != 0);
                i_wt_data <= wt_mem[wt_idx];
            end
        end
    end

    // ====================
    // psum comparator
    // ====================
    always @(posedge clk) begin : check_ps
        int    x;
        int    m;
        psum_t want;
        if (!checking) begin
            ps_cnt    = 0;
            done_cnt  = 0;
            hold_wait = 1'b0;
            i_ps_ack <= 1'b0;
        end else begin
            // a word waiting for ack must hold
            if (hold_wait) begin
                assert (o_ps_rdy) else abort_run("o_ps_rdy dropped before the word was taken");
                assert (o_ps_data === hold_data) else
                    abort_run($sformatf("** Error: o_ps_data = 0x%h, expected held 0x%h",
                                        o_ps_data, hold_data));
            end
            if (o_ps_rdy && i_ps_ack) begin
                assert (ps_cnt < ps_total) else abort_run("more psums delivered than Tw*Pm");
                x    = ps_cnt / int'(cur_conf.pm);
                m    = ps_cnt % int'(cur_conf.pm);
                want = conv_ref(cur_conf, x, m);
                assert (o_ps_data === want) else
                    abort_run($sformatf("** Error: o_ps_data = 0x%h, expected 0x%h (x=%0d m=%0d)",
                                        o_ps_data, want, x, m));
                ps_cnt = ps_cnt + 1;
            end
            hold_wait = o_ps_rdy && !i_ps_ack;
            hold_data = o_ps_data;
            if (o_done) begin
                assert (done_cnt == 0) else abort_run("o_done pulsed more than once in a run");
                assert (ps_cnt == ps_total) else abort_run("o_done came before the last psum");
                assert (!o_busy) else abort_run("o_busy still high in the o_done cycle");
                done_cnt = done_cnt + 1;
            end
            i_ps_ack <= !run_gap_now || (pick_in_range(0, 3) != 0);
        end
    end

    task automatic run_shape(input int k);
        cur_conf    = run_conf[k];
        run_gap_now = run_gaps[k];
        in_total    = int'(cur_conf.pch) * row_words(cur_conf);
        wt_total    = int'(cur_conf.pch) * int'(cur_conf.r) * int'(cur_conf.pm);
        ps_total    = int'(cur_conf.tw) * int'(cur_conf.pm);
        // first two runs use fixed values
        for (int i = 0; i < in_total; i++) begin
            in_mem[i] = (k < 2) ? in_pix_t'(i - 20) : in_pix_t'($random(seed));
        end
        for (int j = 0; j < wt_total; j++) begin
            wt_mem[j] = (k < 2) ? wt_t'(3 * j - 5) : wt_t'($random(seed));
        end
        @(negedge clk);
        feeding  = 1'b1;
        checking = 1'b1;
        @(posedge clk);
        i_start <= 1'b1;
        i_conf  <= cur_conf;
        @(posedge clk);
        i_start <= 1'b0;
        if (run_poke[k]) begin
            repeat (3) @(posedge clk);
            assert (o_busy) else abort_run("DUT was not busy for the second start pulse");
            i_start <= 1'b1;
            i_conf  <= make_conf(1, 1, 1, 1, 1);
            @(posedge clk);
            i_start <= 1'b0;
        end
        while (done_cnt == 0) @(negedge clk);
        // extra psums or a second o_done would show up here
        repeat (4) @(negedge clk);
        feeding  = 1'b0;
        checking = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        int budget;
        run_conf[0] = make_conf(1, 3, 1, 4, 1);
        run_conf[1] = make_conf(2, 2, 2, 8, 2);
        run_conf[2] = make_conf(4, 4, 4, 8, 2);
        for (int k = 3; k < NUM_RUNS - 1; k++) begin
            run_conf[k] = make_conf(pick_in_range(1, 4), pick_in_range(1, 4),
                                    pick_in_range(1, 4), pick_in_range(1, 8),
                                    pick_in_range(1, 2));
        end
        run_conf[NUM_RUNS-1] = make_conf(3, 3, 2, 6, 1);
        budget = 10;
        for (int k = 0; k < NUM_RUNS; k++) begin
            // back-pressure from run 22 on, second start in the final run
            run_gaps[k] = (k >= 22);
            run_poke[k] = (k == NUM_RUNS - 1);
            budget += run_cycles(run_conf[k], run_gaps[k]);
        end
        fork
            begin
                repeat (4 * budget) @(posedge clk);
                abort_run("timeout, the DUT stopped making progress");
            end
        join_none
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!o_in_ack && !o_wt_ack && !o_ps_rdy && !o_busy && !o_done) else
            abort_run("DUT outputs were not low after reset");
        for (int k = 0; k < NUM_RUNS; k++) begin
            run_shape(k);
        end
        $display("test passed");
        $finish;
    end

endmodule
